/* Makefile */
TOP = mmuTb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) \
		-Mdir obj_dir -o V$(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Simulation failed" sim.log || ! grep -q "Simulation passed" sim.log; then \
		echo "simulation run did not pass, see sim.log"; exit 1; \
	fi

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

/* sim.f */
+incdir+verilog
verilog/mmuPkg.sv
verilog/tlbRegs.sv
verilog/tlbArray.sv
verilog/addrTranslate.sv
verilog/mmu.sv
sim/mmu_assertions.sv
sim/mmuTb.sv

/* sim/mmuTb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_params.svh"

module mmuTb;

    localparam int resetCycles = 10;
    localparam int randomReads = 24;
    localparam int cp0Ops      = 40;
    localparam int unmappedOps = 40;
    localparam int rounds      = 30;
    localparam int roundCycles = 64;  // bound on one mapped round of about 48
    localparam int testCycles  = resetCycles + randomReads + 2 * cp0Ops + unmappedOps + 2
                                 + rounds * roundCycles;
    localparam logic [4:0] cp0Regs [6] = '{`CP0_INDEX, `CP0_RANDOM, `CP0_ENTRYLO0,
                                          `CP0_ENTRYLO1, `CP0_BADVADDR, `CP0_ENTRYHI};

    logic              clk;
    logic              reset;
    logic              cp0Wen;
    logic [4:0]        cp0Addr;
    logic [31:0]       cp0Wdata;
    logic [31:0]       cp0Rdata;
    logic              tlbOpValid;
    logic [1:0]        tlbOp;
    logic              xlateValid;
    mmuPkg::xlateReqT  xlateReq;
    logic              xlateRespValid;
    mmuPkg::xlateRespT xlateResp;

    // reference model state
    mmuPkg::tlbEntryT  mEnt [`MMU_ENTRIES];
    logic [3:0]        mRandom;
    logic              mP;
    logic [3:0]        mIdx;
    logic [25:0]       mLo0;
    logic [25:0]       mLo1;
    logic [31:0]       mBadV;
    logic [18:0]       mHiVpn2;
    logic [7:0]        mHiAsid;
    logic [18:0]       vpnPool [8];

    mmuPkg::xlateRespT expQ [$];
    logic [31:0]       vaQ [$];
    int                errors = 0;
    int                checks = 0;

    mmu mmu_inst (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (reset) begin
            mRandom <= 4'd15;
        end else begin
            mRandom <= mRandom - 4'd1;  // 0 wraps to 15
        end
    end

    task automatic check(input string name, input logic [39:0] exp, input logic [39:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    function automatic logic [31:0] expectedRead(input logic [4:0] addr);
        case (addr)
            `CP0_INDEX:    return {mP, 27'b0, mIdx};
            `CP0_RANDOM:   return {28'b0, mRandom};
            `CP0_ENTRYLO0: return {6'b0, mLo0};
            `CP0_ENTRYLO1: return {6'b0, mLo1};
            `CP0_BADVADDR: return mBadV;
            `CP0_ENTRYHI:  return {mHiVpn2, 5'b0, mHiAsid};
            default:       return 32'b0;
        endcase
    endfunction

    // lowest matching index or -1 on a miss
    function automatic int findEntry(input logic [18:0] vpn2);
        for (int i = 0; i < `MMU_ENTRIES; i++) begin
            if (mEnt[i].vpn2 == vpn2 && (mEnt[i].g || mEnt[i].asid == mHiAsid)) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic mmuPkg::xlateRespT expectedResp(input logic [31:0] va, input logic store);
        mmuPkg::xlateRespT r;
        mmuPkg::tlbPageT   pg;
        int                hit;
        logic [4:0]        missCode;
        r        = '0;
        missCode = store ? `EXC_TLBS : `EXC_TLBL;
        if (va[31:30] == 2'b10) begin
            r.paddr  = {3'b000, va[28:0]};
            r.cached = !va[29];  // only kseg0 is cached
            return r;
        end
        hit = findEntry(va[31:13]);
        if (hit < 0) begin
            r.exc     = 1'b1;
            r.refill  = 1'b1;
            r.excCode = missCode;
            return r;
        end
        pg = va[12] ? mEnt[hit].odd : mEnt[hit].even;
        if (!pg.v) begin
            r.exc     = 1'b1;
            r.excCode = missCode;
        end else if (store && !pg.d) begin
            r.exc     = 1'b1;
            r.excCode = `EXC_MOD;
        end else begin
            r.paddr  = {pg.pfn, va[11:0]};
            r.cached = (pg.c == 3'd3);
        end
        return r;
    endfunction

    function automatic logic [18:0] mappedVpn(input logic [18:0] vpn2);
        logic [18:0] v;
        v = vpn2;
        if (v[18:17] == 2'b10) begin
            v[18] = 1'b0;  // stay out of kseg0/kseg1
        end
        return v;
    endfunction

    function automatic logic [31:0] mappedVa();
        logic [18:0] vpn2;
        if ($urandom % 8 == 0) begin
            vpn2 = mappedVpn(19'($urandom));  // most likely a miss
        end else begin
            vpn2 = vpnPool[$urandom % 8];
        end
        return {vpn2, 13'($urandom)};
    endfunction

    function automatic logic [31:0] randomLo();
        logic [31:0] lo;
        lo = $urandom;
        if ($urandom % 4 != 0) begin
            lo[1] = 1'b1;  // mostly valid pages
        end
        return lo;
    endfunction

    task automatic nextCycle();
        @(negedge clk);
        cp0Wen     = 1'b0;
        tlbOpValid = 1'b0;
        xlateValid = 1'b0;
    endtask

    task automatic cp0Write(input logic [4:0] addr, input logic [31:0] data);
        nextCycle();
        cp0Wen   = 1'b1;
        cp0Addr  = addr;
        cp0Wdata = data;
        case (addr)
            `CP0_INDEX:    mIdx = data[3:0];
            `CP0_ENTRYLO0: mLo0 = data[25:0];
            `CP0_ENTRYLO1: mLo1 = data[25:0];
            `CP0_ENTRYHI: begin
                mHiVpn2 = data[31:13];
                mHiAsid = data[7:0];
            end
            default: ;  // Random and BadVAddr are read only
        endcase
    endtask

    task automatic cp0ReadCheck(input string name, input logic [4:0] addr);
        nextCycle();
        cp0Addr = addr;
        #2;
        check(name, expectedRead(addr), cp0Rdata);
    endtask

    task automatic tlbCmd(input logic [1:0] op);
        int         hit;
        logic [3:0] slot;
        nextCycle();
        tlbOpValid = 1'b1;
        tlbOp      = op;
        case (op)
            `TLB_OP_P: begin
                hit = findEntry(mHiVpn2);
                mP  = (hit < 0);
                if (hit >= 0) begin
                    mIdx = hit[3:0];
                end
            end
            `TLB_OP_R: begin
                mHiVpn2 = mEnt[mIdx].vpn2;
                mHiAsid = mEnt[mIdx].asid;
                mLo0    = {mEnt[mIdx].even, mEnt[mIdx].g};
                mLo1    = {mEnt[mIdx].odd, mEnt[mIdx].g};
            end
            default: begin
                slot = (op == `TLB_OP_WR) ? mRandom : mIdx;
                mEnt[slot] = {mHiVpn2, mHiAsid, mLo0[0] & mLo1[0], mLo0[25:1], mLo1[25:1]};
            end
        endcase
    endtask

    task automatic checkResp();
        mmuPkg::xlateRespT exp;
        logic [31:0]       va;
        if (expQ.size() == 0) begin
            return;
        end
        exp = expQ.pop_front();
        va  = vaQ.pop_front();
        check("xlate resp valid", 40'd1, {39'b0, xlateRespValid});
        check($sformatf("xlate %h", va), exp, xlateResp);
        if (exp.exc) begin
            mBadV   = va;
            mHiVpn2 = va[31:13];
        end
    endtask

    // the previous response is checked as the next request goes out
    task automatic xlate(input logic [31:0] va, input logic store);
        nextCycle();
        checkResp();
        xlateValid = 1'b1;
        xlateReq   = {va, store};
        expQ.push_back(expectedResp(va, store));
        vaQ.push_back(va);
    endtask

    task automatic drain();
        nextCycle();
        checkResp();
    endtask

    initial begin
        int          seedDummy;
        int          assertFails;
        logic [4:0]  addr;
        logic [31:0] va;
        seedDummy  = $urandom(477);
        clk        = 1'b0;
        reset      = 1'b1;
        cp0Wen     = 1'b0;
        cp0Addr    = 5'd0;
        cp0Wdata   = 32'd0;
        tlbOpValid = 1'b0;
        tlbOp      = 2'd0;
        xlateValid = 1'b0;
        xlateReq   = '0;
        for (int i = 0; i < `MMU_ENTRIES; i++) begin
            mEnt[i] = '0;
        end
        mP      = 1'b0;
        mIdx    = '0;
        mLo0    = '0;
        mLo1    = '0;
        mBadV   = '0;
        mHiVpn2 = '0;
        mHiAsid = '0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        reset   = 1'b0;
        cp0Addr = `CP0_RANDOM;
        #2;
        check("reset resp valid", 40'd0, {39'b0, xlateRespValid});
        check("reset random", 40'd15, {8'b0, cp0Rdata});
        repeat (randomReads) cp0ReadCheck("random countdown", `CP0_RANDOM);

        for (int i = 0; i < cp0Ops; i++) begin
            addr = cp0Regs[$urandom % 6];
            cp0Write(addr, $urandom);
            cp0ReadCheck("cp0 readback", addr);
        end

        for (int i = 0; i < unmappedOps; i++) begin
            xlate({2'b10, 30'($urandom)}, 1'($urandom));
        end
        drain();

        for (int i = 0; i < 8; i++) begin
            vpnPool[i] = mappedVpn(19'($urandom));
        end
        for (int r = 0; r < rounds; r++) begin
            for (int k = 0; k < 4; k++) begin
                cp0Write(`CP0_ENTRYHI, {vpnPool[$urandom % 8], 5'b0, 8'($urandom % 3)});
                cp0Write(`CP0_ENTRYLO0, randomLo());
                cp0Write(`CP0_ENTRYLO1, randomLo());
                if ($urandom % 2 == 0) begin
                    tlbCmd(`TLB_OP_WR);
                end else begin
                    cp0Write(`CP0_INDEX, $urandom);
                    tlbCmd(`TLB_OP_WI);
                end
            end
            cp0Write(`CP0_ENTRYHI, {19'($urandom), 5'b0, 8'($urandom % 3)});
            for (int k = 0; k < 16; k++) begin
                xlate(mappedVa(), 1'($urandom));
            end
            drain();
            cp0ReadCheck("exc badvaddr", `CP0_BADVADDR);
            cp0ReadCheck("exc entryhi", `CP0_ENTRYHI);
            va = mappedVa();
            cp0Write(`CP0_ENTRYHI, {va[31:13], 5'b0, 8'($urandom % 3)});
            tlbCmd(`TLB_OP_P);
            cp0ReadCheck("tlbp index", `CP0_INDEX);
            cp0Write(`CP0_INDEX, $urandom);
            tlbCmd(`TLB_OP_R);
            cp0ReadCheck("tlbr entryhi", `CP0_ENTRYHI);
            cp0ReadCheck("tlbr entrylo0", `CP0_ENTRYLO0);
            cp0ReadCheck("tlbr entrylo1", `CP0_ENTRYLO1);
        end

        nextCycle();
        assertFails = mmu_inst.mmuAssertions_inst.failCount;
        $display("%0d checks, %0d errors, %0d assertion failures",
                 checks, errors, assertFails);
        if (errors == 0 && assertFails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(testCycles * 8 + 2000);
        $display("watchdog expired before all tests finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/mmu_assertions.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_params.svh"

module mmuAssertions (
    input wire                    clk,
    input wire                    reset,
    input wire                    xlateValid,
    input wire                    xlateRespValid,
    input wire mmuPkg::xlateRespT xlateResp
);

    int failCount = 0;

    // one response per request exactly one cycle later
    respTiming: assert property (@(posedge clk) disable iff (reset)
        xlateRespValid == $past(xlateValid))
        else begin
            $error("xlateRespValid does not follow xlateValid by one cycle");
            failCount++;
        end

    excZeroAddr: assert property (@(posedge clk) disable iff (reset)
        (xlateRespValid && xlateResp.exc) |-> (xlateResp.paddr == 32'b0))
        else begin
            $error("exception response with a nonzero physical address");
            failCount++;
        end

    refillCode: assert property (@(posedge clk) disable iff (reset)
        (xlateRespValid && xlateResp.refill)
            |-> (xlateResp.excCode == `EXC_TLBL || xlateResp.excCode == `EXC_TLBS))
        else begin
            $error("refill response with a code other than TLBL or TLBS");
            failCount++;
        end

endmodule

bind mmu mmuAssertions mmuAssertions_inst (
    .clk            (clk),
    .reset          (reset),
    .xlateValid     (xlateValid),
    .xlateRespValid (xlateRespValid),
    .xlateResp      (xlateResp)
);

`default_nettype wire

/* verilog/addrTranslate.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_params.svh"

module addrTranslate (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            xlateValid,
    input  wire mmuPkg::xlateReqT          xlateReq,
    output mmuPkg::vaddrU                  searchVaddr,
    input  wire mmuPkg::tlbHitT            lookupHit,
    output logic                           xlateRespValid,
    output mmuPkg::xlateRespT              xlateResp,
    output logic [31:0]                    excVaddr
);

    mmuPkg::xlateRespT nextResp;
    logic [2:0]        seg;
    logic [4:0]        missCode;

    assign searchVaddr = xlateReq.vaddr;
    assign seg         = xlateReq.vaddr.segView.seg;
    assign missCode    = xlateReq.store ? `EXC_TLBS : `EXC_TLBL;

    always_comb begin
        nextResp = '0;
        if (seg == 3'b100 || seg == 3'b101) begin
            // kseg0 / kseg1, fixed map to low 512M
            nextResp.paddr  = {3'b000, xlateReq.vaddr.segView.rest};
            nextResp.cached = (seg == 3'b100);
        end else if (!lookupHit.found) begin
            nextResp.exc     = 1'b1;
            nextResp.refill  = 1'b1;
            nextResp.excCode = missCode;
        end else if (!lookupHit.page.v) begin
            nextResp.exc     = 1'b1;  // invalid
            nextResp.excCode = missCode;
        end else if (xlateReq.store && !lookupHit.page.d) begin
            nextResp.exc     = 1'b1;  // store to clean page
            nextResp.excCode = `EXC_MOD;
        end else begin
            nextResp.paddr  = {lookupHit.page.pfn, xlateReq.vaddr.page.offset};
            nextResp.cached = (lookupHit.page.c == 3'd3);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            xlateRespValid <= 1'b0;
        end else begin
            xlateRespValid <= xlateValid;
        end
    end

    always_ff @(posedge clk) begin
        if (xlateValid) begin
            xlateResp <= nextResp;
            excVaddr  <= xlateReq.vaddr;
        end
    end

endmodule

`default_nettype wire

/* verilog/mmu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_params.svh"

module mmu (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            cp0Wen,
    input  wire [4:0]                      cp0Addr,
    input  wire [31:0]                     cp0Wdata,
    output logic [31:0]                    cp0Rdata,
    input  wire                            tlbOpValid,
    input  wire [1:0]                      tlbOp,
    input  wire                            xlateValid,
    input  wire mmuPkg::xlateReqT          xlateReq,
    output logic                           xlateRespValid,
    output mmuPkg::xlateRespT              xlateResp
);

    logic                    writeEn;
    logic [`MMU_INDEX_W-1:0] writeIndex;
    mmuPkg::tlbEntryT        writeEntry;
    logic [`MMU_INDEX_W-1:0] readIndex;
    mmuPkg::tlbEntryT        readEntry;
    logic [`MMU_VPN2_W-1:0]  probeVpn2;
    logic [`MMU_ASID_W-1:0]  curAsid;
    mmuPkg::tlbHitT          probeHit;
    mmuPkg::tlbHitT          lookupHit;
    mmuPkg::vaddrU           searchVaddr;
    logic [31:0]             excVaddr;

    // cp0 side, produces entries and commands
    tlbRegs tlbRegs_inst (
        .clk            (clk),
        .reset          (reset),
        .cp0Wen         (cp0Wen),
        .cp0Addr        (cp0Addr),
        .cp0Wdata       (cp0Wdata),
        .cp0Rdata       (cp0Rdata),
        .tlbOpValid     (tlbOpValid),
        .tlbOp          (tlbOp),
        .probeHit       (probeHit),
        .readEntry      (readEntry),
        .xlateRespValid (xlateRespValid),
        .xlateResp      (xlateResp),
        .excVaddr       (excVaddr),
        .writeEn        (writeEn),
        .writeIndex     (writeIndex),
        .writeEntry     (writeEntry),
        .readIndex      (readIndex),
        .probeVpn2      (probeVpn2),
        .curAsid        (curAsid)
    );

    tlbArray tlbArray_inst (
        .clk         (clk),
        .reset       (reset),
        .writeEn     (writeEn),
        .writeIndex  (writeIndex),
        .writeEntry  (writeEntry),
        .readIndex   (readIndex),
        .readEntry   (readEntry),
        .curAsid     (curAsid),
        .probeVpn2   (probeVpn2),
        .probeHit    (probeHit),
        .searchVaddr (searchVaddr),
        .lookupHit   (lookupHit)
    );

    addrTranslate addrTranslate_inst (
        .clk            (clk),
        .reset          (reset),
        .xlateValid     (xlateValid),
        .xlateReq       (xlateReq),
        .searchVaddr    (searchVaddr),
        .lookupHit      (lookupHit),
        .xlateRespValid (xlateRespValid),
        .xlateResp      (xlateResp),
        .excVaddr       (excVaddr)
    );

endmodule

`default_nettype wire

/* verilog/mmuPkg.sv */
`default_nettype none
`include "mmu_params.svh"

package mmuPkg;

    typedef struct packed {
        logic [`MMU_VPN2_W-1:0] vpn2;
        logic                   odd;     // even/odd page select
        logic [11:0]            offset;
    } vaPageT;

    typedef struct packed {
        logic [2:0]  seg;
        logic [28:0] rest;
    } vaSegT;

    // one address, read as TLB page fields or as a segment
    typedef union packed {
        vaPageT page;
        vaSegT  segView;
    } vaddrU;

    typedef struct packed {
        logic [`MMU_PFN_W-1:0] pfn;
        logic [2:0]            c;
        logic                  d;
        logic                  v;
    } tlbPageT;

    typedef struct packed {
        logic [`MMU_VPN2_W-1:0] vpn2;
        logic [`MMU_ASID_W-1:0] asid;
        logic                   g;
        tlbPageT                even;
        tlbPageT                odd;
    } tlbEntryT;

    typedef struct packed {
        logic                    found;
        logic [`MMU_INDEX_W-1:0] index;
        tlbPageT                 page;
    } tlbHitT;

    // EntryLo bits 25:0, pfn down to g
    typedef struct packed {
        tlbPageT page;
        logic    g;
    } entryLoT;

    typedef struct packed {
        vaddrU vaddr;
        logic  store;
    } xlateReqT;

    typedef struct packed {
        logic [31:0] paddr;
        logic        cached;
        logic        exc;
        logic        refill;
        logic [4:0]  excCode;
    } xlateRespT;

endpackage

`default_nettype wire

/* verilog/mmu_params.svh */
`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

// TLB geometry
`define MMU_ENTRIES 16
`define MMU_INDEX_W 4
`define MMU_ASID_W  8
`define MMU_VPN2_W  19
`define MMU_PFN_W   20

// cp0 register numbers
`define CP0_INDEX    5'd0
`define CP0_RANDOM   5'd1
`define CP0_ENTRYLO0 5'd2
`define CP0_ENTRYLO1 5'd3
`define CP0_BADVADDR 5'd8
`define CP0_ENTRYHI  5'd10

// tlb instructions
`define TLB_OP_P  2'd0
`define TLB_OP_R  2'd1
`define TLB_OP_WI 2'd2
`define TLB_OP_WR 2'd3

// exception codes
`define EXC_MOD  5'd1
`define EXC_TLBL 5'd2
`define EXC_TLBS 5'd3

`endif

/* verilog/tlbArray.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_params.svh"

module tlbArray (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            writeEn,
    input  wire [`MMU_INDEX_W-1:0]         writeIndex,
    input  wire mmuPkg::tlbEntryT          writeEntry,
    input  wire [`MMU_INDEX_W-1:0]         readIndex,
    output mmuPkg::tlbEntryT               readEntry,
    input  wire [`MMU_ASID_W-1:0]          curAsid,
    input  wire [`MMU_VPN2_W-1:0]          probeVpn2,
    output mmuPkg::tlbHitT                 probeHit,
    input  wire mmuPkg::vaddrU             searchVaddr,
    output mmuPkg::tlbHitT                 lookupHit
);

    mmuPkg::tlbEntryT entries [`MMU_ENTRIES];

    function automatic logic entryMatch(
        input mmuPkg::tlbEntryT       e,
        input logic [`MMU_VPN2_W-1:0] vpn2,
        input logic [`MMU_ASID_W-1:0] asid
    );
        return (e.vpn2 == vpn2) && (e.g || (e.asid == asid));
    endfunction

    // scan downwards, so the lowest matching index is the one left
    function automatic mmuPkg::tlbHitT search(
        input logic [`MMU_VPN2_W-1:0] vpn2,
        input logic [`MMU_ASID_W-1:0] asid,
        input logic                   odd
    );
        mmuPkg::tlbHitT hit;
        hit = '0;
        for (int i = `MMU_ENTRIES - 1; i >= 0; i--) begin
            if (entryMatch(entries[i], vpn2, asid)) begin
                hit.found = 1'b1;
                hit.index = i[`MMU_INDEX_W-1:0];
                hit.page  = odd ? entries[i].odd : entries[i].even;
            end
        end
        return hit;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MMU_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (writeEn) begin
            entries[writeIndex] <= writeEntry;
        end
    end

    assign readEntry = entries[readIndex];

    always_comb begin
        lookupHit = search(searchVaddr.page.vpn2, curAsid, searchVaddr.page.odd);
    end

    always_comb begin
        probeHit      = search(probeVpn2, curAsid, 1'b0);
        probeHit.page = '0;  // found and index only
    end

endmodule

`default_nettype wire

/* verilog/tlbRegs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_params.svh"

module tlbRegs (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            cp0Wen,
    input  wire [4:0]                      cp0Addr,
    input  wire [31:0]                     cp0Wdata,
    output logic [31:0]                    cp0Rdata,
    input  wire                            tlbOpValid,
    input  wire [1:0]                      tlbOp,
    input  wire mmuPkg::tlbHitT            probeHit,
    input  wire mmuPkg::tlbEntryT          readEntry,
    input  wire                            xlateRespValid,
    input  wire mmuPkg::xlateRespT         xlateResp,
    input  wire [31:0]                     excVaddr,
    output logic                           writeEn,
    output logic [`MMU_INDEX_W-1:0]        writeIndex,
    output mmuPkg::tlbEntryT               writeEntry,
    output logic [`MMU_INDEX_W-1:0]        readIndex,
    output logic [`MMU_VPN2_W-1:0]         probeVpn2,
    output logic [`MMU_ASID_W-1:0]         curAsid
);

    logic                    indexP;
    logic [`MMU_INDEX_W-1:0] indexVal;
    logic [`MMU_INDEX_W-1:0] randomIdx;
    mmuPkg::entryLoT         entryLo0;
    mmuPkg::entryLoT         entryLo1;
    logic [31:0]             badVAddr;
    logic [`MMU_VPN2_W-1:0]  hiVpn2;
    logic [`MMU_ASID_W-1:0]  hiAsid;
    logic                    opProbe;
    logic                    opRead;
    logic                    excUpdate;

    assign opProbe   = tlbOpValid && (tlbOp == `TLB_OP_P);
    assign opRead    = tlbOpValid && (tlbOp == `TLB_OP_R);
    assign writeEn   = tlbOpValid && (tlbOp == `TLB_OP_WI || tlbOp == `TLB_OP_WR);
    assign writeIndex = (tlbOp == `TLB_OP_WR) ? randomIdx : indexVal;
    assign readIndex = indexVal;
    assign probeVpn2 = hiVpn2;
    assign curAsid   = hiAsid;
    assign excUpdate = xlateRespValid && xlateResp.exc;

    always_comb begin
        writeEntry.vpn2 = hiVpn2;
        writeEntry.asid = hiAsid;
        writeEntry.g    = entryLo0.g & entryLo1.g;  // global only if both halves say so
        writeEntry.even = entryLo0.page;
        writeEntry.odd  = entryLo1.page;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            randomIdx <= `MMU_INDEX_W'(`MMU_ENTRIES - 1);
        end else begin
            randomIdx <= randomIdx - 1'b1;  // wraps 0 -> 15
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            indexP   <= 1'b0;
            indexVal <= '0;
            entryLo0 <= '0;
            entryLo1 <= '0;
            badVAddr <= '0;
            hiVpn2   <= '0;
            hiAsid   <= '0;
        end else begin
            if (cp0Wen) begin
                case (cp0Addr)
                    `CP0_INDEX:    indexVal <= cp0Wdata[`MMU_INDEX_W-1:0];
                    `CP0_ENTRYLO0: entryLo0 <= cp0Wdata[25:0];
                    `CP0_ENTRYLO1: entryLo1 <= cp0Wdata[25:0];
                    `CP0_ENTRYHI: begin
                        hiVpn2 <= cp0Wdata[31:13];
                        hiAsid <= cp0Wdata[`MMU_ASID_W-1:0];
                    end
                    default: ;
                endcase
            end
            if (opProbe) begin
                indexP <= ~probeHit.found;
                if (probeHit.found) begin
                    indexVal <= probeHit.index;
                end
            end
            if (opRead) begin
                hiVpn2        <= readEntry.vpn2;
                hiAsid        <= readEntry.asid;
                entryLo0.page <= readEntry.even;
                entryLo0.g    <= readEntry.g;
                entryLo1.page <= readEntry.odd;
                entryLo1.g    <= readEntry.g;
            end
            // faulting address overrides anything else this cycle
            if (excUpdate) begin
                badVAddr <= excVaddr;
                hiVpn2   <= excVaddr[31:13];
            end
        end
    end

    always_comb begin
        case (cp0Addr)
            `CP0_INDEX:    cp0Rdata = {indexP, 27'b0, indexVal};
            `CP0_RANDOM:   cp0Rdata = {28'b0, randomIdx};
            `CP0_ENTRYLO0: cp0Rdata = {6'b0, entryLo0};
            `CP0_ENTRYLO1: cp0Rdata = {6'b0, entryLo1};
            `CP0_BADVADDR: cp0Rdata = badVAddr;
            `CP0_ENTRYHI:  cp0Rdata = {hiVpn2, 5'b0, hiAsid};
            default:       cp0Rdata = 32'b0;
        endcase
    end

endmodule

`default_nettype wire
